// File: common/riscv_m_pkg.sv
// RISC-V M extension definitions
// word widths, funct3 encodings and the two decoded views of the op field
package riscv_m_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // funct3 under OP with funct7 = 0000001
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;
    localparam logic [2:0] F3_DIV    = 3'b100;
    localparam logic [2:0] F3_DIVU   = 3'b101;
    localparam logic [2:0] F3_REM    = 3'b110;
    localparam logic [2:0] F3_REMU   = 3'b111;

    // multiply kind, low two bits of funct3
    localparam logic [1:0] MUL_KIND_LO  = 2'b00;
    localparam logic [1:0] MUL_KIND_HSS = 2'b01;
    localparam logic [1:0] MUL_KIND_HSU = 2'b10;
    localparam logic [1:0] MUL_KIND_HUU = 2'b11;

    // multiply side: high/sign kind
    typedef struct packed {
        logic       is_div;
        logic [1:0] kind;
    } mul_view_t;

    // divide side: bit 1 picks remainder, bit 0 unsigned
    typedef struct packed {
        logic is_div;
        logic is_rem;
        logic is_unsigned;
    } div_view_t;

    typedef union packed {
        mul_view_t mul;
        div_view_t div;
    } muldiv_op_u;

endpackage

// File: common/muldiv_pkg.sv
// multiply/divide block traffic
// request, unit command, unit status and register write-back records
package muldiv_pkg;

    // decoded M instruction from the pipeline
    typedef struct packed {
        logic                    valid;
        riscv_m_pkg::muldiv_op_u op;
        riscv_m_pkg::xlen_t      rs1;
        riscv_m_pkg::xlen_t      rs2;
        riscv_m_pkg::reg_addr_t  rd;
    } muldiv_req_t;

    // controller to unit
    typedef struct packed {
        logic                    start;
        riscv_m_pkg::muldiv_op_u op;
        riscv_m_pkg::xlen_t      a;
        riscv_m_pkg::xlen_t      b;
        riscv_m_pkg::reg_addr_t  rd;
    } unit_cmd_t;

    // unit to controller, result and rd valid with ready
    typedef struct packed {
        logic                   busy;
        logic                   ready;
        riscv_m_pkg::xlen_t     result;
        riscv_m_pkg::reg_addr_t rd;
    } unit_rsp_t;

    // register file write port
    typedef struct packed {
        logic                   we;
        riscv_m_pkg::reg_addr_t waddr;
        riscv_m_pkg::xlen_t     wdata;
    } wb_t;

endpackage

// File: muldiv/mul_unit.sv
`timescale 1ns/1ns

// iterative shift-add multiplier for MUL, MULH, MULHSU and MULHU
module mul_unit #(
    parameter int MUL_BITS_PER_CYCLE = 2
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  muldiv_pkg::unit_cmd_t cmd_i,
    output muldiv_pkg::unit_rsp_t rsp_o
);

    localparam int XLEN  = riscv_m_pkg::XLEN;
    localparam int STEPS = XLEN / MUL_BITS_PER_CYCLE;
    localparam int CNT_W = $clog2(STEPS);

    logic                    busy_q;
    logic                    ready_q;
    logic [CNT_W-1:0]        cnt_q;
    riscv_m_pkg::muldiv_op_u op_q;
    riscv_m_pkg::reg_addr_t  rd_q;
    logic [2*XLEN-1:0]       acc_q;
    logic [2*XLEN-1:0]       mcand_q;
    logic [XLEN-1:0]         mplier_q;

    logic                    accept;
    logic                    a_signed;
    logic                    b_signed;
    logic [2*XLEN-1:0]       a_ext;
    logic [2*XLEN-1:0]       acc_init;
    logic [2*XLEN-1:0]       partial;

    if (MUL_BITS_PER_CYCLE != 1 && MUL_BITS_PER_CYCLE != 2 &&
        MUL_BITS_PER_CYCLE != 4) begin : g_bad_bits
        $error("MUL_BITS_PER_CYCLE must be 1, 2 or 4");
    end

    assign accept   = cmd_i.start & ~busy_q & ~ready_q;
    assign a_signed = (cmd_i.op.mul.kind == riscv_m_pkg::MUL_KIND_HSS) |
                      (cmd_i.op.mul.kind == riscv_m_pkg::MUL_KIND_HSU);
    assign b_signed = (cmd_i.op.mul.kind == riscv_m_pkg::MUL_KIND_HSS);
    assign a_ext    = {{XLEN{a_signed & cmd_i.a[XLEN-1]}}, cmd_i.a};

    // only the low XLEN multiplier bits are iterated
    // a signed negative b weighs its top bit as -2^XLEN, so preload that term
    always_comb begin
        acc_init = '0;
        if (b_signed && cmd_i.b[XLEN-1]) begin
            acc_init = acc_init - {a_ext[XLEN-1:0], {XLEN{1'b0}}};
        end
    end

    // partial product of this step's multiplier digit
    always_comb begin
        partial = '0;
        for (int i = 0; i < MUL_BITS_PER_CYCLE; i++) begin
            if (mplier_q[i]) begin
                partial = partial + (mcand_q << i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            ready_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            ready_q <= busy_q && (cnt_q == '0);
            if (accept) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(STEPS - 1);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == '0) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q     <= cmd_i.op;
            rd_q     <= cmd_i.rd;
            acc_q    <= acc_init;
            mcand_q  <= a_ext;
            mplier_q <= cmd_i.b;
        end else if (busy_q) begin
            acc_q    <= acc_q + partial;
            mcand_q  <= mcand_q << MUL_BITS_PER_CYCLE;
            mplier_q <= mplier_q >> MUL_BITS_PER_CYCLE;
        end
    end

    assign rsp_o.busy   = busy_q;
    assign rsp_o.ready  = ready_q;
    // MUL takes the low word, the three high forms the upper one
    assign rsp_o.result = (op_q.mul.kind == riscv_m_pkg::MUL_KIND_LO) ?
                          acc_q[XLEN-1:0] : acc_q[2*XLEN-1:XLEN];
    assign rsp_o.rd     = rd_q;

    // ready comes only right after a busy stretch
    a_ready_after_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_o.ready |-> !rsp_o.busy && $past(rsp_o.busy))
        else $error("multiplier ready outside its slot");

endmodule

// File: muldiv/div_unit.sv
`timescale 1ns/1ns

// iterative restoring divider for DIV, DIVU, REM and REMU
// divide by zero and signed overflow finish without iterating
module div_unit (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  muldiv_pkg::unit_cmd_t cmd_i,
    output muldiv_pkg::unit_rsp_t rsp_o
);

    localparam int XLEN  = riscv_m_pkg::XLEN;
    localparam int CNT_W = $clog2(XLEN);

    logic                   busy_q;
    logic                   ready_q;
    logic                   skip_q;
    logic [CNT_W-1:0]       cnt_q;
    riscv_m_pkg::reg_addr_t rd_q;
    logic                   is_rem_q;
    logic                   quo_neg_q;
    logic                   rem_neg_q;
    riscv_m_pkg::xlen_t     quo_q;
    riscv_m_pkg::xlen_t     rem_q;
    riscv_m_pkg::xlen_t     dsor_q;

    logic                   accept;
    logic                   op_signed;
    logic                   a_neg;
    logic                   b_neg;
    logic                   div_zero;
    logic                   overflow;
    riscv_m_pkg::xlen_t     a_abs;
    riscv_m_pkg::xlen_t     b_abs;
    logic [XLEN:0]          rem_sh;
    logic [XLEN:0]          diff;
    riscv_m_pkg::xlen_t     quo_fix;
    riscv_m_pkg::xlen_t     rem_fix;

    assign accept    = cmd_i.start & ~busy_q & ~ready_q;
    assign op_signed = ~cmd_i.op.div.is_unsigned;
    assign a_neg     = op_signed & cmd_i.a[XLEN-1];
    assign b_neg     = op_signed & cmd_i.b[XLEN-1];
    assign a_abs     = a_neg ? (~cmd_i.a + 1'b1) : cmd_i.a;
    assign b_abs     = b_neg ? (~cmd_i.b + 1'b1) : cmd_i.b;
    assign div_zero  = (cmd_i.b == '0);
    // most negative over minus one
    assign overflow  = op_signed & (cmd_i.a == {1'b1, {(XLEN-1){1'b0}}}) & (&cmd_i.b);

    // shift next dividend bit into the partial remainder and trial subtract
    assign rem_sh = {rem_q, quo_q[XLEN-1]};
    assign diff   = rem_sh - {1'b0, dsor_q};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            ready_q <= 1'b0;
            skip_q  <= 1'b0;
            cnt_q   <= '0;
        end else begin
            ready_q <= busy_q && (cnt_q == '0);
            if (accept) begin
                busy_q <= 1'b1;
                skip_q <= div_zero | overflow;
                cnt_q  <= (div_zero | overflow) ? '0 : CNT_W'(XLEN - 1);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == '0) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_q     <= cmd_i.rd;
            is_rem_q <= cmd_i.op.div.is_rem;
            dsor_q   <= b_abs;
            if (div_zero) begin
                // quotient all ones, remainder is the dividend
                quo_q     <= '1;
                rem_q     <= cmd_i.a;
                quo_neg_q <= 1'b0;
                rem_neg_q <= 1'b0;
            end else if (overflow) begin
                quo_q     <= cmd_i.a;
                rem_q     <= '0;
                quo_neg_q <= 1'b0;
                rem_neg_q <= 1'b0;
            end else begin
                quo_q     <= a_abs;
                rem_q     <= '0;
                quo_neg_q <= a_neg ^ b_neg;
                // remainder follows the dividend sign
                rem_neg_q <= a_neg;
            end
        end else if (busy_q && !skip_q) begin
            // negative trial restores the shifted remainder
            rem_q <= diff[XLEN] ? rem_sh[XLEN-1:0] : diff[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], ~diff[XLEN]};
        end
    end

    assign quo_fix = quo_neg_q ? (~quo_q + 1'b1) : quo_q;
    assign rem_fix = rem_neg_q ? (~rem_q + 1'b1) : rem_q;

    assign rsp_o.busy   = busy_q;
    assign rsp_o.ready  = ready_q;
    assign rsp_o.result = is_rem_q ? rem_fix : quo_fix;
    assign rsp_o.rd     = rd_q;

    // ready comes only right after a busy stretch
    a_ready_after_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_o.ready |-> !rsp_o.busy && $past(rsp_o.busy))
        else $error("divider ready outside its slot");

endmodule

// File: muldiv/muldiv_ctrl.sv
`timescale 1ns/1ns

// multiply/divide controller
// starts the selected unit, holds the pipeline and merges both result paths
module muldiv_ctrl (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  muldiv_pkg::muldiv_req_t req_i,
    input  logic                    int_assert_i,
    input  muldiv_pkg::unit_rsp_t   mul_rsp_i,
    input  muldiv_pkg::unit_rsp_t   div_rsp_i,
    output muldiv_pkg::unit_cmd_t   mul_cmd_o,
    output muldiv_pkg::unit_cmd_t   div_cmd_o,
    output logic                    hold_o,
    output muldiv_pkg::wb_t         wb_o
);

    logic any_busy;
    logic sel_div;
    logic can_start;

    assign any_busy  = mul_rsp_i.busy | div_rsp_i.busy;
    assign sel_div   = req_i.op.div.is_div;
    // interrupt only blocks new work
    assign can_start = req_i.valid & ~int_assert_i;

    always_comb begin
        // operands fan out to both units, start picks one
        mul_cmd_o.start = 1'b0;
        mul_cmd_o.op    = req_i.op;
        mul_cmd_o.a     = req_i.rs1;
        mul_cmd_o.b     = req_i.rs2;
        mul_cmd_o.rd    = req_i.rd;

        div_cmd_o.start = 1'b0;
        div_cmd_o.op    = req_i.op;
        div_cmd_o.a     = req_i.rs1;
        div_cmd_o.b     = req_i.rs2;
        div_cmd_o.rd    = req_i.rd;

        hold_o     = 1'b0;
        wb_o.we    = 1'b0;
        wb_o.waddr = '0;
        wb_o.wdata = '0;

        if (any_busy) begin
            // unit running, keep the pipeline parked
            hold_o = 1'b1;
        end else if (div_rsp_i.ready) begin
            wb_o.we    = 1'b1;
            wb_o.waddr = div_rsp_i.rd;
            wb_o.wdata = div_rsp_i.result;
        end else if (mul_rsp_i.ready) begin
            wb_o.we    = 1'b1;
            wb_o.waddr = mul_rsp_i.rd;
            wb_o.wdata = mul_rsp_i.result;
        end else if (can_start) begin
            // both units idle here
            hold_o = 1'b1;
            if (sel_div) begin
                div_cmd_o.start = 1'b1;
            end else begin
                mul_cmd_o.start = 1'b1;
            end
        end
    end

    // a start only reaches an idle unit
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(mul_cmd_o.start && (mul_rsp_i.busy || mul_rsp_i.ready)) &&
        !(div_cmd_o.start && (div_rsp_i.busy || div_rsp_i.ready)))
        else $error("start raised toward a unit that is not idle");

    // one unit at a time
    a_single_start: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(mul_cmd_o.start && div_cmd_o.start))
        else $error("both units started in one cycle");

    // write-back always releases the pipeline
    a_wb_no_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(wb_o.we && hold_o))
        else $error("write-back while holding the pipeline");

endmodule

// File: verilog/muldiv_top.sv
`timescale 1ns/1ns

// M extension execute block
// controller plus iterative multiplier and divider
module muldiv_top #(
    parameter int MUL_BITS_PER_CYCLE = 2
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  muldiv_pkg::muldiv_req_t req_i,
    input  logic                    int_assert_i,
    output logic                    hold_o,
    output muldiv_pkg::wb_t         wb_o
);

    muldiv_pkg::unit_cmd_t mul_cmd;
    muldiv_pkg::unit_cmd_t div_cmd;
    muldiv_pkg::unit_rsp_t mul_rsp;
    muldiv_pkg::unit_rsp_t div_rsp;

    muldiv_ctrl u_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .int_assert_i (int_assert_i),
        .mul_rsp_i    (mul_rsp),
        .div_rsp_i    (div_rsp),
        .mul_cmd_o    (mul_cmd),
        .div_cmd_o    (div_cmd),
        .hold_o       (hold_o),
        .wb_o         (wb_o)
    );

    mul_unit #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) u_mul (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .cmd_i   (mul_cmd),
        .rsp_o   (mul_rsp)
    );

    div_unit u_div (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .cmd_i   (div_cmd),
        .rsp_o   (div_rsp)
    );

endmodule

// File: bench/tb_muldiv_model.svh
// M extension result model, xorshift generator and directed stimulus table
// included inside the muldiv testbench module
`ifndef TB_MULDIV_MODEL_SVH
`define TB_MULDIV_MODEL_SVH

// expected result straight from the RISC-V M rules
function automatic riscv_m_pkg::xlen_t ref_result(input logic [2:0] op,
                                                  input riscv_m_pkg::xlen_t a,
                                                  input riscv_m_pkg::xlen_t b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic signed [31:0] sres;
    logic signed [63:0] sa64;
    logic signed [63:0] sb64;
    logic [63:0]        prod;
    logic               sdiv_ovf;
    riscv_m_pkg::xlen_t res;
    sa       = a;
    sb       = b;
    sdiv_ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    res      = '0;
    case (op)
        riscv_m_pkg::F3_MUL: begin
            prod = {32'b0, a} * {32'b0, b};
            res  = prod[31:0];
        end
        riscv_m_pkg::F3_MULH: begin
            sa64 = sa;
            sb64 = sb;
            prod = sa64 * sb64;
            res  = prod[63:32];
        end
        riscv_m_pkg::F3_MULHSU: begin
            sa64 = sa;
            sb64 = {32'b0, b};
            prod = sa64 * sb64;
            res  = prod[63:32];
        end
        riscv_m_pkg::F3_MULHU: begin
            prod = {32'b0, a} * {32'b0, b};
            res  = prod[63:32];
        end
        // division rounds toward zero, as SV does
        riscv_m_pkg::F3_DIV: begin
            if (b == 0) begin
                res = '1;
            end else if (sdiv_ovf) begin
                res = a;
            end else begin
                sres = sa / sb;
                res  = sres;
            end
        end
        riscv_m_pkg::F3_DIVU: res = (b == 0) ? '1 : a / b;
        riscv_m_pkg::F3_REM: begin
            if (b == 0) begin
                res = a;
            end else if (sdiv_ovf) begin
                res = '0;
            end else begin
                sres = sa % sb;
                res  = sres;
            end
        end
        riscv_m_pkg::F3_REMU: res = (b == 0) ? a : a % b;
        default: res = '0;
    endcase
    return res;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

typedef struct {
    string                  name;
    logic [2:0]             op;
    riscv_m_pkg::xlen_t     a;
    riscv_m_pkg::xlen_t     b;
    riscv_m_pkg::reg_addr_t rd;
    logic                   irq;
} stim_t;

localparam int NUM_STIM = 20;

// name, funct3, rs1, rs2, rd, interrupt raised first
stim_t stim_tbl [NUM_STIM] = '{
    '{"mul_small",    riscv_m_pkg::F3_MUL,    32'h0000_0007, 32'h0000_0006, 5'd1,  1'b0},
    '{"mul_neg",      riscv_m_pkg::F3_MUL,    32'hffff_fffd, 32'h0000_0005, 5'd2,  1'b0},
    '{"mulh_min_min", riscv_m_pkg::F3_MULH,   32'h8000_0000, 32'h8000_0000, 5'd3,  1'b0},
    '{"mulh_mixed",   riscv_m_pkg::F3_MULH,   32'hffff_fff0, 32'h1234_5678, 5'd4,  1'b0},
    '{"mulhsu_neg",   riscv_m_pkg::F3_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 5'd5,  1'b0},
    '{"mulhsu_pos",   riscv_m_pkg::F3_MULHSU, 32'h7fff_ffff, 32'hffff_ffff, 5'd6,  1'b0},
    '{"mulhu_max",    riscv_m_pkg::F3_MULHU,  32'hffff_ffff, 32'hffff_ffff, 5'd7,  1'b0},
    '{"mulhu_mix",    riscv_m_pkg::F3_MULHU,  32'h1234_5678, 32'h9abc_def0, 5'd8,  1'b0},
    '{"div_pos",      riscv_m_pkg::F3_DIV,    32'd100,       32'd7,         5'd9,  1'b0},
    '{"div_neg",      riscv_m_pkg::F3_DIV,    32'hffff_ff9c, 32'd7,         5'd10, 1'b0},
    '{"div_zero",     riscv_m_pkg::F3_DIV,    32'd5,         32'd0,         5'd11, 1'b0},
    '{"div_ovf",      riscv_m_pkg::F3_DIV,    32'h8000_0000, 32'hffff_ffff, 5'd12, 1'b0},
    '{"divu_big",     riscv_m_pkg::F3_DIVU,   32'hffff_ffff, 32'd3,         5'd13, 1'b0},
    '{"divu_zero",    riscv_m_pkg::F3_DIVU,   32'd1234,      32'd0,         5'd14, 1'b0},
    '{"rem_neg",      riscv_m_pkg::F3_REM,    32'hffff_ff9c, 32'd7,         5'd15, 1'b0},
    '{"rem_ovf",      riscv_m_pkg::F3_REM,    32'h8000_0000, 32'hffff_ffff, 5'd16, 1'b0},
    '{"rem_zero",     riscv_m_pkg::F3_REM,    32'hffff_fff7, 32'd0,         5'd17, 1'b0},
    '{"remu_basic",   riscv_m_pkg::F3_REMU,   32'hdead_beef, 32'h0000_1000, 5'd18, 1'b0},
    '{"mul_irq",      riscv_m_pkg::F3_MUL,    32'h0000_1234, 32'h0000_5678, 5'd19, 1'b1},
    '{"divu_irq",     riscv_m_pkg::F3_DIVU,   32'h0bad_f00d, 32'h0000_0123, 5'd20, 1'b1}
};

`endif

// File: bench/tb_muldiv.sv
`timescale 1ns/1ns

// testbench for the M extension execute block
// directed table, interrupt blocking and random back-to-back ops
module tb_muldiv;

    localparam int XLEN       = riscv_m_pkg::XLEN;
    localparam int MUL_BITS   = 2;
    localparam int NUM_RANDOM = 40;
    localparam int WAIT_LIMIT = XLEN + 10;

    `include "tb_muldiv_model.svh"

    localparam int WATCHDOG_NS = (NUM_STIM + NUM_RANDOM) * (XLEN + 10) * 4;

    logic                    clk;
    logic                    rst_n_i;
    muldiv_pkg::muldiv_req_t req;
    logic                    int_assert;
    logic                    hold;
    muldiv_pkg::wb_t         wb;
    int                      errors;
    logic [31:0]             rng;

    muldiv_top #(
        .MUL_BITS_PER_CYCLE (MUL_BITS)
    ) DUT (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (req),
        .int_assert_i (int_assert),
        .hold_o       (hold),
        .wb_o         (wb)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // cycles from the start cycle to the write-back cycle
    function automatic int op_latency(input logic [2:0] op, input riscv_m_pkg::xlen_t a,
                                      input riscv_m_pkg::xlen_t b);
        logic signed_div;
        signed_div = (op == riscv_m_pkg::F3_DIV) || (op == riscv_m_pkg::F3_REM);
        if (!op[2]) begin
            return XLEN / MUL_BITS + 1;
        end
        if (b == 0 || (signed_div && a == 32'h8000_0000 && b == 32'hffff_ffff)) begin
            return 2;
        end
        return XLEN + 1;
    endfunction

    task automatic check_word(input string name, input string field,
                              input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Error %s %s: expected %h, actual %h", name, field, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input string field,
                               input int exp, input int act);
        assert (act == exp) else begin
            $display("Error %s %s: expected %0d, actual %0d", name, field, exp, act);
            errors++;
        end
    endtask

    task automatic run_op(input string name, input logic [2:0] op,
                          input riscv_m_pkg::xlen_t a, input riscv_m_pkg::xlen_t b,
                          input riscv_m_pkg::reg_addr_t rd, input logic irq);
        riscv_m_pkg::xlen_t exp_data;
        int                 exp_lat;
        int                 cycles;
        logic               seen_wb;
        exp_data = ref_result(op, a, b);
        exp_lat  = op_latency(op, a, b);
        cycles   = 0;
        seen_wb  = 1'b0;
        @(posedge clk);
        #1;
        req.valid  = 1'b1;
        req.op     = op;
        req.rs1    = a;
        req.rs2    = b;
        req.rd     = rd;
        int_assert = irq;
        if (irq) begin
            // a pending interrupt keeps the request from starting
            repeat (XLEN + 4) begin
                @(negedge clk);
                assert (!hold && !wb.we) else begin
                    $display("interrupt did not block test %s, hold or write-back seen", name);
                    errors++;
                end
            end
            @(posedge clk);
            #1;
            int_assert = 1'b0;
        end
        while (!seen_wb && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            if (wb.we) begin
                seen_wb = 1'b1;
                check_word(name, "wdata", exp_data, wb.wdata);
                check_word(name, "waddr", 32'(rd), 32'(wb.waddr));
                check_count(name, "latency", exp_lat, cycles);
                assert (!hold) else begin
                    $display("hold still high in the write-back cycle of test %s", name);
                    errors++;
                end
            end else begin
                assert (hold) else begin
                    $display("hold dropped before write-back in test %s at cycle %0d",
                             name, cycles);
                    errors++;
                end
                cycles++;
            end
        end
        assert (seen_wb) else begin
            $display("no write-back within %0d cycles in test %s", WAIT_LIMIT, name);
            errors++;
        end
    endtask

    // one idle cycle, write-back must not repeat
    task automatic drop_request();
        @(posedge clk);
        #1;
        req.valid  = 1'b0;
        int_assert = 1'b0;
        @(negedge clk);
        assert (!wb.we && !hold) else begin
            $display("write-back repeated or hold stuck after the request was dropped");
            errors++;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the run finished");
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [2:0]             r_op;
        riscv_m_pkg::xlen_t     r_a;
        riscv_m_pkg::xlen_t     r_b;
        riscv_m_pkg::reg_addr_t r_rd;
        errors     = 0;
        rst_n_i    = 1'b0;
        req        = '0;
        int_assert = 1'b0;
        rng        = 32'hb2ec;
        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        repeat (3) begin
            @(negedge clk);
            assert (!hold && !wb.we) else begin
                $display("hold or write-back active after reset with no request");
                errors++;
            end
        end

        for (int i = 0; i < NUM_STIM; i++) begin
            run_op(stim_tbl[i].name, stim_tbl[i].op, stim_tbl[i].a, stim_tbl[i].b,
                   stim_tbl[i].rd, stim_tbl[i].irq);
            drop_request();
        end

        // back to back, next request right after each write-back
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng  = xorshift32(rng);
            r_op = rng[2:0];
            r_rd = rng[12:8];
            rng  = xorshift32(rng);
            r_a  = rng;
            rng  = xorshift32(rng);
            // vary the divisor size
            r_b  = rng >> rng[31:27];
            run_op($sformatf("rand_%0d", i), r_op, r_a, r_b, r_rd, 1'b0);
        end
        drop_request();

        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+bench
common/riscv_m_pkg.sv
common/muldiv_pkg.sv
muldiv/mul_unit.sv
muldiv/div_unit.sv
muldiv/muldiv_ctrl.sv
verilog/muldiv_top.sv
bench/tb_muldiv.sv
